/* source/isa_pkg.sv */
package isa_pkg;

    localparam int INST_W       = 8;
    localparam int REG_IDX_W    = 3;
    localparam int IMM_W        = 8;
    localparam int ADDR_HI_W    = 2;    // high address bits held in bits 1..0 of the opcode
    localparam int ADDR_W       = ADDR_HI_W + INST_W;
    localparam int IMM_FLAG_BIT = 4;    // alu bytes only

    typedef logic [INST_W-1:0]    inst_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [IMM_W-1:0]     imm_t;

    // bits 7..5
    typedef enum logic [2:0] {
        BASE_CTRL = 3'b000,
        BASE_ADD  = 3'b001,
        BASE_SUB  = 3'b010,
        BASE_AND  = 3'b011,
        BASE_OR   = 3'b100,
        BASE_XOR  = 3'b101,
        BASE_LD   = 3'b110,
        BASE_ST   = 3'b111
    } base_op_t;

    // bits 4..3 of a control byte
    typedef enum logic [1:0] {
        CTRL_MISC = 2'b00,
        CTRL_USR  = 2'b01,
        CTRL_JMP  = 2'b10,
        CTRL_CALL = 2'b11
    } ctrl_op_t;

    // bits 2..0 of a misc byte, remaining codes illegal
    typedef enum logic [2:0] {
        MISC_NOP  = 3'b000,
        MISC_RET  = 3'b001,
        MISC_HALT = 3'b010,
        MISC_RST  = 3'b011
    } misc_op_t;

endpackage

/* source/exec_pkg.sv */
package exec_pkg;

    typedef enum logic [3:0] {
        EXEC_NOP    = 4'd0,
        EXEC_ADD    = 4'd1,
        EXEC_SUB    = 4'd2,
        EXEC_AND    = 4'd3,
        EXEC_OR     = 4'd4,
        EXEC_XOR    = 4'd5,
        EXEC_MEM_RD = 4'd6,
        EXEC_MEM_WR = 4'd7,
        EXEC_JMP    = 4'd8,
        EXEC_CALL   = 4'd9,
        EXEC_RET    = 4'd10
    } exec_op_t;

    // command to the execute unit, 34 bits
    typedef struct packed {
        exec_op_t          op;
        isa_pkg::reg_idx_t src0;
        logic              src0_rd_en;
        isa_pkg::reg_idx_t src1;
        logic              src1_rd_en;
        isa_pkg::reg_idx_t dst;
        isa_pkg::addr_t    addr;
        isa_pkg::imm_t     imm;
        logic              imm_vld;
    } exec_cmd_t;

    // one-cycle pulses to the cpu controller
    typedef struct packed {
        logic call;
        logic branch;
        logic ret;
        logic soft_rst;
        logic halted;
        logic illegal;
    } cpu_cmd_t;

    // what a single opcode byte tells us
    typedef struct packed {
        exec_op_t                       op;
        isa_pkg::reg_idx_t              src0;
        logic                           src0_rd_en;
        isa_pkg::reg_idx_t              src1;
        logic                           src1_rd_en;
        isa_pkg::reg_idx_t              dst;
        logic                           two_byte;
        logic [isa_pkg::ADDR_HI_W-1:0]  addr_hi;
        logic                           ret;
        logic                           halt;
        logic                           soft_rst;
        logic                           illegal;
    } opcode_info_t;

    localparam exec_cmd_t EXEC_CMD_RST = '0;   // op comes out as EXEC_NOP

endpackage

/* source/opcode_decoder.sv */
`timescale 1ns/100ps

module opcode_decoder (
    input  isa_pkg::inst_t         inst,
    output exec_pkg::opcode_info_t info
);

    isa_pkg::base_op_t  base;
    isa_pkg::ctrl_op_t  ctrl;
    isa_pkg::misc_op_t  misc;
    exec_pkg::exec_op_t alu_op;

    assign base = isa_pkg::base_op_t'(inst[7:5]);
    assign ctrl = isa_pkg::ctrl_op_t'(inst[4:3]);
    assign misc = isa_pkg::misc_op_t'(inst[2:0]);

    // alu group maps one to one onto execute ops
    always_comb begin
        case (base)
            isa_pkg::BASE_ADD: alu_op = exec_pkg::EXEC_ADD;
            isa_pkg::BASE_SUB: alu_op = exec_pkg::EXEC_SUB;
            isa_pkg::BASE_AND: alu_op = exec_pkg::EXEC_AND;
            isa_pkg::BASE_OR:  alu_op = exec_pkg::EXEC_OR;
            isa_pkg::BASE_XOR: alu_op = exec_pkg::EXEC_XOR;
            default:           alu_op = exec_pkg::EXEC_NOP;
        endcase
    end

    always_comb begin
        info = '0;
        case (base)
            isa_pkg::BASE_CTRL: begin
                case (ctrl)
                    isa_pkg::CTRL_MISC: begin
                        case (misc)
                            isa_pkg::MISC_NOP: begin
                                info.op = exec_pkg::EXEC_NOP;
                            end
                            isa_pkg::MISC_RET: begin
                                info.op  = exec_pkg::EXEC_RET;
                                info.ret = 1'b1;
                            end
                            isa_pkg::MISC_HALT: begin
                                info.halt = 1'b1;
                            end
                            isa_pkg::MISC_RST: begin
                                info.soft_rst = 1'b1;
                            end
                            default: begin
                                info.illegal = 1'b1;    // old bc codes land here too
                            end
                        endcase
                    end
                    isa_pkg::CTRL_JMP: begin
                        info.op       = exec_pkg::EXEC_JMP;
                        info.two_byte = 1'b1;
                        info.addr_hi  = inst[isa_pkg::ADDR_HI_W-1:0];
                    end
                    isa_pkg::CTRL_CALL: begin
                        info.op       = exec_pkg::EXEC_CALL;
                        info.two_byte = 1'b1;
                        info.addr_hi  = inst[isa_pkg::ADDR_HI_W-1:0];
                    end
                    default: begin
                        info.illegal = 1'b1;    // usr group
                    end
                endcase
            end
            isa_pkg::BASE_LD: begin
                info.op       = exec_pkg::EXEC_MEM_RD;
                info.dst      = inst[4:2];
                info.two_byte = 1'b1;
                info.addr_hi  = inst[isa_pkg::ADDR_HI_W-1:0];
            end
            isa_pkg::BASE_ST: begin
                info.op         = exec_pkg::EXEC_MEM_WR;
                info.src0       = inst[4:2];
                info.src0_rd_en = 1'b1;
                info.two_byte   = 1'b1;
                info.addr_hi    = inst[isa_pkg::ADDR_HI_W-1:0];
            end
            default: begin
                // alu, register fields are only two bits wide
                info.op         = alu_op;
                info.src0       = isa_pkg::reg_idx_t'(inst[3:2]);
                info.src0_rd_en = 1'b1;
                info.dst        = isa_pkg::reg_idx_t'(inst[1:0]);
                info.two_byte   = inst[isa_pkg::IMM_FLAG_BIT];
                if (!inst[isa_pkg::IMM_FLAG_BIT]) begin
                    info.src1       = isa_pkg::reg_idx_t'(inst[1:0]);
                    info.src1_rd_en = 1'b1;
                end
            end
        endcase
    end

endmodule

/* source/operand_sequencer.sv */
`timescale 1ns/100ps

module operand_sequencer (
    input  logic                   clk,
    input  logic                   reset_,
    input  logic                   decode_en,
    input  isa_pkg::inst_t         inst,
    input  exec_pkg::opcode_info_t info,
    output exec_pkg::exec_cmd_t    exec_cmd,
    output logic                   exec_en,
    output exec_pkg::cpu_cmd_t     cpu_cmd
);

    typedef enum logic {
        OPCODE,
        OPERAND
    } seq_state_t;

    seq_state_t             state;
    seq_state_t             state_next;
    exec_pkg::opcode_info_t pend;       // first byte of a two-byte instruction
    exec_pkg::opcode_info_t sel;
    exec_pkg::exec_cmd_t    cmd_next;
    exec_pkg::cpu_cmd_t     cpu_next;
    logic                   take_opcode;
    logic                   complete;
    logic                   exec_en_next;

    function automatic logic is_alu(exec_pkg::exec_op_t op);
        case (op)
            exec_pkg::EXEC_ADD,
            exec_pkg::EXEC_SUB,
            exec_pkg::EXEC_AND,
            exec_pkg::EXEC_OR,
            exec_pkg::EXEC_XOR: is_alu = 1'b1;
            default:            is_alu = 1'b0;
        endcase
    endfunction

    function automatic logic writes_dst(exec_pkg::exec_op_t op);
        writes_dst = is_alu(op) || (op == exec_pkg::EXEC_MEM_RD);
    endfunction

    always_comb begin
        sel         = (state == OPERAND) ? pend : info;
        take_opcode = decode_en && (state == OPCODE) && info.two_byte;
        complete    = decode_en &&
                      ((state == OPERAND) || (!info.illegal && !info.two_byte));
        state_next  = state;
        if (take_opcode)
            state_next = OPERAND;
        else if (decode_en && (state == OPERAND))
            state_next = OPCODE;
    end

    // merge into the held command, undefined fields keep their value
    always_comb begin
        cmd_next = exec_cmd;
        if (complete) begin
            cmd_next.op         = sel.op;
            cmd_next.src0_rd_en = sel.src0_rd_en;
            cmd_next.src1_rd_en = sel.src1_rd_en;
            cmd_next.imm_vld    = sel.two_byte && is_alu(sel.op);
            if (sel.src0_rd_en)
                cmd_next.src0 = sel.src0;
            if (sel.src1_rd_en)
                cmd_next.src1 = sel.src1;
            if (writes_dst(sel.op))
                cmd_next.dst = sel.dst;
            if (sel.two_byte) begin
                case (sel.op)
                    exec_pkg::EXEC_MEM_RD,
                    exec_pkg::EXEC_MEM_WR: begin
                        cmd_next.addr = {sel.addr_hi, inst};
                    end
                    exec_pkg::EXEC_JMP,
                    exec_pkg::EXEC_CALL: begin
                        cmd_next.addr = {sel.addr_hi, inst};
                        cmd_next.imm  = inst;
                    end
                    default: begin
                        cmd_next.imm = inst;    // alu immediate
                    end
                endcase
            end
        end
    end

    always_comb begin
        cpu_next          = '0;
        cpu_next.call     = complete && (sel.op == exec_pkg::EXEC_CALL);
        cpu_next.branch   = complete && (sel.op == exec_pkg::EXEC_JMP);
        cpu_next.ret      = complete && sel.ret;
        cpu_next.halted   = complete && sel.halt;
        cpu_next.soft_rst = complete && sel.soft_rst;
        cpu_next.illegal  = decode_en && (state == OPCODE) && info.illegal;
        exec_en_next      = complete && !sel.halt && !sel.soft_rst;
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            state    <= OPCODE;
            exec_cmd <= exec_pkg::EXEC_CMD_RST;
            exec_en  <= 1'b0;
            cpu_cmd  <= '0;
        end else begin
            state    <= state_next;
            exec_cmd <= cmd_next;
            exec_en  <= exec_en_next;
            cpu_cmd  <= cpu_next;
        end
    end

    // only read while in OPERAND
    always_ff @(posedge clk) begin
        if (take_opcode)
            pend <= info;
    end

endmodule

/* source/instr_decode.sv */
`timescale 1ns/100ps

module instr_decode (
    input  logic                clk,
    input  logic                reset_,
    input  logic                decode_en,
    input  isa_pkg::inst_t      inst,
    output exec_pkg::exec_cmd_t exec_cmd,
    output logic                exec_en,
    output exec_pkg::cpu_cmd_t  cpu_cmd
);

    exec_pkg::opcode_info_t info;   // classification of the byte on inst

    opcode_decoder opcode_decoder_inst (
        .inst (inst),
        .info (info)
    );

    operand_sequencer operand_sequencer_inst (
        .clk       (clk),
        .reset_    (reset_),
        .decode_en (decode_en),
        .inst      (inst),
        .info      (info),
        .exec_cmd  (exec_cmd),
        .exec_en   (exec_en),
        .cpu_cmd   (cpu_cmd)
    );

endmodule

/* bench/instr_decode_checker.sv */
`timescale 1ns/100ps

module instr_decode_checker (
    input logic               clk,
    input logic               reset_,
    input logic               decode_en,
    input logic               exec_en,
    input exec_pkg::cpu_cmd_t cpu_cmd
);

    // a byte either executes or is rejected
    a_exec_not_illegal: assert property (
        @(posedge clk) disable iff (!reset_)
        !(exec_en && cpu_cmd.illegal)
    ) else $error("exec_en and illegal high in the same cycle");

    a_branch_has_exec: assert property (
        @(posedge clk) disable iff (!reset_)
        (cpu_cmd.branch || cpu_cmd.call) |-> exec_en
    ) else $error("branch or call pulse without exec_en");

    // halt and soft reset go to the controller only
    a_stop_no_exec: assert property (
        @(posedge clk) disable iff (!reset_)
        (cpu_cmd.halted || cpu_cmd.soft_rst) |-> !exec_en
    ) else $error("halted or soft_rst pulse together with exec_en");

    a_idle_clears: assert property (
        @(posedge clk) disable iff (!reset_)
        !decode_en |=> (!exec_en && (cpu_cmd == '0))
    ) else $error("pulse still high after a cycle without decode_en");

endmodule

/* bench/instr_decode_tb.sv */
`timescale 1ns/100ps

module instr_decode_tb;

    localparam logic [31:0] SEED            = 32'h026b09c0;
    localparam int          NUM_INSTR       = 400;
    localparam int          RESET_CYCLES    = 8;
    localparam int          DIRECTED_CYCLES = 100;  // upper bound for the directed tests
    // random stream spends at most two cycles per byte
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + DIRECTED_CYCLES + 2 * NUM_INSTR);

    typedef struct packed {
        logic                operand;   // waiting for the second byte
        isa_pkg::inst_t      first;
        exec_pkg::exec_cmd_t cmd;
        logic                exec_en;
        exec_pkg::cpu_cmd_t  cpu;
    } model_t;

    logic                clk = 1'b0;
    logic                reset_;
    logic                decode_en;
    isa_pkg::inst_t      inst;
    exec_pkg::exec_cmd_t exec_cmd;
    logic                exec_en;
    exec_pkg::cpu_cmd_t  cpu_cmd;

    model_t      model;
    logic        check_en = 1'b0;
    string       test_name;
    string       check_name;
    logic [31:0] rng;
    int          error_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          test_err_start;

    instr_decode instr_decode_inst (
        .clk       (clk),
        .reset_    (reset_),
        .decode_en (decode_en),
        .inst      (inst),
        .exec_cmd  (exec_cmd),
        .exec_en   (exec_en),
        .cpu_cmd   (cpu_cmd)
    );

    bind instr_decode instr_decode_checker checker_inst (
        .clk       (clk),
        .reset_    (reset_),
        .decode_en (decode_en),
        .exec_en   (exec_en),
        .cpu_cmd   (cpu_cmd)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic exec_pkg::exec_op_t alu_exec_op(logic [2:0] base);
        case (base)
            3'b001:  return exec_pkg::EXEC_ADD;
            3'b010:  return exec_pkg::EXEC_SUB;
            3'b011:  return exec_pkg::EXEC_AND;
            3'b100:  return exec_pkg::EXEC_OR;
            3'b101:  return exec_pkg::EXEC_XOR;
            default: return exec_pkg::EXEC_NOP;
        endcase
    endfunction

    // expected state and outputs after one consumed byte
    function automatic model_t ref_decode(model_t m, isa_pkg::inst_t b);
        model_t         r;
        isa_pkg::inst_t f;
        r         = m;
        r.exec_en = 1'b0;
        r.cpu     = '0;
        if (!m.operand) begin
            if (b[7:3] == 5'b00001 || (b[7:3] == 5'b00000 && b[2])) begin
                r.cpu.illegal = 1'b1;   // usr group or unused misc code
            end else if (b[7:3] == 5'b00000) begin
                r.cmd.op         = exec_pkg::EXEC_NOP;
                r.cmd.src0_rd_en = 1'b0;
                r.cmd.src1_rd_en = 1'b0;
                r.cmd.imm_vld    = 1'b0;
                case (b[1:0])
                    2'b00: r.exec_en = 1'b1;
                    2'b01: begin
                        r.cmd.op  = exec_pkg::EXEC_RET;
                        r.exec_en = 1'b1;
                        r.cpu.ret = 1'b1;
                    end
                    2'b10:   r.cpu.halted   = 1'b1;
                    default: r.cpu.soft_rst = 1'b1;
                endcase
            end else if (b[7:5] <= 3'b101 && !b[4]) begin
                r.cmd.op         = alu_exec_op(b[7:5]);
                r.cmd.src0       = {1'b0, b[3:2]};
                r.cmd.src1       = {1'b0, b[1:0]};
                r.cmd.dst        = {1'b0, b[1:0]};
                r.cmd.src0_rd_en = 1'b1;
                r.cmd.src1_rd_en = 1'b1;
                r.cmd.imm_vld    = 1'b0;
                r.exec_en        = 1'b1;
            end else begin
                r.operand = 1'b1;
                r.first   = b;
            end
        end else begin
            f                = m.first;
            r.operand        = 1'b0;
            r.exec_en        = 1'b1;
            r.cmd.src0_rd_en = 1'b0;
            r.cmd.src1_rd_en = 1'b0;
            r.cmd.imm_vld    = 1'b0;
            case (f[7:5])
                3'b110: begin
                    r.cmd.op   = exec_pkg::EXEC_MEM_RD;
                    r.cmd.dst  = f[4:2];
                    r.cmd.addr = {f[1:0], b};
                end
                3'b111: begin
                    r.cmd.op         = exec_pkg::EXEC_MEM_WR;
                    r.cmd.src0       = f[4:2];
                    r.cmd.src0_rd_en = 1'b1;
                    r.cmd.addr       = {f[1:0], b};
                end
                3'b000: begin
                    r.cmd.addr = {f[1:0], b};
                    r.cmd.imm  = b;
                    if (f[3]) begin
                        r.cmd.op   = exec_pkg::EXEC_CALL;
                        r.cpu.call = 1'b1;
                    end else begin
                        r.cmd.op     = exec_pkg::EXEC_JMP;
                        r.cpu.branch = 1'b1;
                    end
                end
                default: begin
                    r.cmd.op         = alu_exec_op(f[7:5]);
                    r.cmd.src0       = {1'b0, f[3:2]};
                    r.cmd.src0_rd_en = 1'b1;
                    r.cmd.dst        = {1'b0, f[1:0]};
                    r.cmd.imm        = b;
                    r.cmd.imm_vld    = 1'b1;
                end
            endcase
        end
        return r;
    endfunction

    always @(posedge clk) begin
        check_name = test_name;
        check_en  <= 1'b1;
        if (!reset_) begin
            model <= '0;    // op NOP is the zero code
        end else if (decode_en) begin
            model <= ref_decode(model, inst);
        end else begin
            model.exec_en <= 1'b0;
            model.cpu     <= '0;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (check_en) begin
            check_count++;
            assert (exec_en == model.exec_en) else begin
                $display("FAIL %s exec_en expected %0b actual %0b",
                         check_name, model.exec_en, exec_en);
                error_count++;
            end
            assert (cpu_cmd == model.cpu) else begin
                $display("FAIL %s cpu_cmd expected %b actual %b",
                         check_name, model.cpu, cpu_cmd);
                error_count++;
            end
            assert (exec_cmd == model.cmd) else begin
                $display("FAIL %s exec_cmd expected %h actual %h",
                         check_name, model.cmd, exec_cmd);
                error_count++;
            end
        end
    end

    task automatic drive_byte(input isa_pkg::inst_t b);
        decode_en = 1'b1;
        inst      = b;
        @(negedge clk);
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            rng       = xorshift32(rng);
            decode_en = 1'b0;
            inst      = rng[7:0];   // not consumed
            @(negedge clk);
        end
    endtask

    task automatic drive_pair(input isa_pkg::inst_t b0, input isa_pkg::inst_t b1, input int gap);
        drive_byte(b0);
        drive_idle(gap);
        drive_byte(b1);
    endtask

    task automatic finish_test();
        decode_en = 1'b0;
        @(posedge clk);
        tests_run++;
        $display("test %s finished with %0d mismatches", test_name,
                 error_count - test_err_start);
        test_err_start = error_count;
        @(negedge clk);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: stimulus still running after %0d cycles", cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rng            = SEED;
        test_err_start = 0;
        reset_         = 1'b0;
        decode_en      = 1'b0;
        inst           = '0;
        test_name      = "reset";
        repeat (RESET_CYCLES) @(negedge clk);
        reset_ = 1'b1;
        drive_idle(3);
        finish_test();

        test_name = "alu_reg";
        drive_byte(8'h26);
        drive_byte(8'h4c);
        drive_idle(1);
        drive_byte(8'h6b);
        drive_byte(8'h81);
        drive_byte(8'haf);
        finish_test();

        test_name = "two_byte";
        drive_pair(8'h39, 8'ha5, 0);
        drive_pair(8'h57, 8'h3c, 1);
        drive_pair(8'h7c, 8'hff, 2);
        drive_pair(8'h92, 8'h00, 0);
        drive_pair(8'hb5, 8'h5a, 0);
        drive_pair(8'hd6, 8'h81, 1);    // operand looks like an opcode
        drive_pair(8'hed, 8'h7e, 3);
        finish_test();

        test_name = "jump_call";
        drive_pair(8'h13, 8'hc4, 0);
        drive_pair(8'h1a, 8'h37, 1);
        drive_byte(8'h01);
        drive_byte(8'h02);
        drive_idle(1);
        drive_byte(8'h03);
        drive_byte(8'h00);
        finish_test();

        test_name = "illegal";
        drive_byte(8'h08);
        drive_byte(8'h25);
        drive_byte(8'h0f);
        drive_byte(8'h04);
        drive_byte(8'h05);
        drive_idle(1);
        drive_byte(8'h06);
        drive_byte(8'h07);
        drive_pair(8'hc1, 8'h10, 0);
        drive_pair(8'h10, 8'h08, 0);    // usr code as operand byte
        drive_byte(8'h0c);
        drive_byte(8'h01);
        finish_test();

        test_name = "random";
        for (int i = 0; i < NUM_INSTR; i++) begin
            rng = xorshift32(rng);
            if (rng[9:8] == 2'b00)
                drive_idle(1);
            rng = xorshift32(rng);
            drive_byte(rng[7:0]);
        end
        finish_test();
        @(posedge clk);

        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* instr_decode.f */
source/isa_pkg.sv
source/exec_pkg.sv
source/opcode_decoder.sv
source/operand_sequencer.sv
source/instr_decode.sv
bench/instr_decode_checker.sv
bench/instr_decode_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module instr_decode_tb \
    -Mdir obj_dir \
    -f instr_decode.f

./obj_dir/Vinstr_decode_tb | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
